// File: verilog/pkg_mpu.sv
/*
 * Shared sizes and types of the thread-management front end.
 * Widths follow from the sizes below; change them together.
 * Instruction store depth must be a power of two.
 */

package pkg_mpu;

	////////////////////////////////////////////////////////////////////////////
	// Sizes
	////////////////////////////////////////////////////////////////////////////

	localparam int NUM_THREADS     = 8;            // Thread-map entries
	localparam int WIDTH_THREAD_ID = 3;

	localparam int SIZE_THREAD_MEM = 64;           // Instruction store words
	localparam int WIDTH_T_ADDR    = 6;
	localparam int WIDTH_T_LEN     = 7;            // One bit wider so 64 fits

	localparam int WIDTH_INSTR     = 32;

	localparam int NUM_ISSUE       = 4;            // Outstanding issues
	localparam int WIDTH_ISSUE_NO  = 4;            // Tag wraps modulo 16
	localparam int WIDTH_ISSUE_PTR = 2;            // Index into outstanding list

	////////////////////////////////////////////////////////////////////////////
	// Vector types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [WIDTH_THREAD_ID-1:0] id_t;
	typedef logic [WIDTH_T_ADDR-1:0]    t_address_t;
	typedef logic [WIDTH_T_LEN-1:0]     t_length_t;
	typedef logic [WIDTH_INSTR-1:0]     instr_t;
	typedef logic [WIDTH_ISSUE_NO-1:0]  issue_no_t;
	typedef logic [WIDTH_ISSUE_PTR-1:0] issue_ptr_t;
	typedef logic [WIDTH_ISSUE_PTR:0]   issue_cnt_t;   // Counts 0 to NUM_ISSUE

	////////////////////////////////////////////////////////////////////////////
	// Bundles
	////////////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic       valid;                         // Entry holds a stored thread
		t_address_t base;                          // First word in the store
		t_length_t  length;                        // Words in the thread
	} lookup_t;

	typedef struct packed {
		id_t       thread;
		t_length_t length;
	} st_cmd_t;

	typedef struct packed {
		logic mem_full;
		logic map_full;
		logic commit_full;
		logic busy;
	} mpu_stat_t;

	typedef enum logic [1:0] {
		IDLE,
		LOOKUP,
		STREAM
	} disp_state_t;

endpackage

// File: verilog/thread_mem.sv
/*
 * Append-only instruction store. Space is never reclaimed.
 * Words on st_valid are taken only once a store has been granted.
 * Read data appears one cycle after rd_en.
 */

module thread_mem (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                st_grant,
	input  logic                st_valid,
	input  pkg_mpu::instr_t     st_instr,
	output pkg_mpu::t_length_t  used_size,
	input  logic                rd_en,
	input  pkg_mpu::t_address_t rd_addr,
	output pkg_mpu::instr_t     rd_instr,
	output logic                mem_full
);

	pkg_mpu::instr_t     mem [pkg_mpu::SIZE_THREAD_MEM];
	logic                wr_open;                 // Set by the first grant
	logic                wr_en;
	pkg_mpu::t_address_t wr_addr;

	assign wr_en    = st_valid & wr_open;
	assign wr_addr  = used_size[pkg_mpu::WIDTH_T_ADDR-1:0];   // Append pointer
	assign mem_full = used_size == pkg_mpu::t_length_t'(pkg_mpu::SIZE_THREAD_MEM);

	////////////////////////////////////////////////////////////////////////////
	// Append pointer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			used_size <= '0;
			wr_open   <= 1'b0;
		end
		else begin
			if (st_grant) begin
				wr_open <= 1'b1;
			end
			if (wr_en) begin
				used_size <= used_size + 1'b1;   // Only grows
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Storage and read port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= st_instr;
		end
	end

	always_ff @(posedge clock) begin
		if (rd_en) begin
			rd_instr <= mem[rd_addr];            // Registered read
		end
	end

	// Host sends exactly the granted word count, so a full store sees no data
	a_no_write_full: assert property (
		@(posedge clock) disable iff (!rst_n)
		wr_en |-> !mem_full
	) else $error("instruction word written while store is full");

endmodule

// File: verilog/map_man.sv
/*
 * Thread map indexed by thread number, so an entry is either free or
 * already owned by the same thread. Re-storing replaces the entry.
 * Zero-length stores are rejected. Lookup result is one cycle late.
 */

module map_man (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                st_req,
	input  pkg_mpu::st_cmd_t    st_cmd,
	input  pkg_mpu::t_length_t  used_size,
	output logic                st_grant,
	output logic                st_err,
	input  logic                lookup_req,
	input  pkg_mpu::id_t        lookup_thread,
	output pkg_mpu::lookup_t    lookup_info,
	output logic                map_full
);

	logic [pkg_mpu::NUM_THREADS-1:0] entry_valid;
	pkg_mpu::t_address_t             entry_base [pkg_mpu::NUM_THREADS];
	pkg_mpu::t_length_t              entry_len  [pkg_mpu::NUM_THREADS];

	pkg_mpu::t_length_t              free_words;
	logic                            fits;

	////////////////////////////////////////////////////////////////////////////
	// Store acceptance
	////////////////////////////////////////////////////////////////////////////

	assign free_words = pkg_mpu::t_length_t'(pkg_mpu::SIZE_THREAD_MEM) - used_size;
	assign fits       = (st_cmd.length != '0) && (st_cmd.length <= free_words);
	assign st_grant   = st_req & fits;            // Same cycle as the command

	assign map_full   = &entry_valid;

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			entry_valid <= '0;
			st_err      <= 1'b0;
		end
		else begin
			st_err <= st_req & ~fits;            // Pulse one cycle later
			if (st_grant) begin
				entry_valid[st_cmd.thread] <= 1'b1;
			end
		end
	end

	// Base is the append pointer at grant time
	always_ff @(posedge clock) begin
		if (st_grant) begin
			entry_base[st_cmd.thread] <= used_size[pkg_mpu::WIDTH_T_ADDR-1:0];
			entry_len[st_cmd.thread]  <= st_cmd.length;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Lookup
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (lookup_req) begin
			lookup_info.valid  <= entry_valid[lookup_thread];
			lookup_info.base   <= entry_base[lookup_thread];
			lookup_info.length <= entry_len[lookup_thread];
		end
	end

endmodule

// File: verilog/commit_track.sv
/*
 * Issue number allocator and ordered list of outstanding issues.
 * Commits must arrive oldest first; any other number is refused.
 * Caller must not issue while commit_full is high.
 */

module commit_track (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               issue_req,
	output pkg_mpu::issue_no_t issue_no,
	input  logic               commit_req,
	input  pkg_mpu::issue_no_t commit_no,
	output logic               commit_err,
	output logic               commit_full
);

	pkg_mpu::issue_no_t  next_no;
	pkg_mpu::issue_no_t  fifo [pkg_mpu::NUM_ISSUE];
	pkg_mpu::issue_ptr_t head;
	pkg_mpu::issue_ptr_t tail;
	pkg_mpu::issue_cnt_t count;
	logic                in_order;
	logic                retire;

	assign issue_no    = next_no;
	assign in_order    = (count != '0) && (fifo[head] == commit_no);
	assign retire      = commit_req & in_order;
	assign commit_full = count == pkg_mpu::issue_cnt_t'(pkg_mpu::NUM_ISSUE);

	////////////////////////////////////////////////////////////////////////////
	// Pointers and counters
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			next_no    <= '0;
			head       <= '0;
			tail       <= '0;
			count      <= '0;
			commit_err <= 1'b0;
		end
		else begin
			commit_err <= commit_req & ~in_order;   // Nothing retired on error
			if (issue_req) begin
				next_no <= next_no + 1'b1;          // Wraps modulo 16
				tail    <= tail + 1'b1;
			end
			if (retire) begin
				head <= head + 1'b1;
			end
			case ({issue_req, retire})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (issue_req) begin
			fifo[tail] <= next_no;
		end
	end

	// Busy from the top level blocks new runs while the list is full
	a_no_issue_full: assert property (
		@(posedge clock) disable iff (!rst_n)
		issue_req |-> !commit_full
	) else $error("issue request while outstanding list is full");

endmodule

// File: verilog/dispatch.sv
/*
 * Run sequencer: looks up a thread, reads it word by word and streams
 * it out with one issue tag. Runs are refused by protocol while busy.
 * First word leaves three cycles after run_req.
 */

module dispatch (
	input  logic                clock,
	input  logic                rst_n,
	input  logic                run_req,
	input  pkg_mpu::id_t        run_thread,
	input  logic                commit_full,
	output logic                lookup_req,
	output pkg_mpu::id_t        lookup_thread,
	input  pkg_mpu::lookup_t    lookup_info,
	output logic                rd_en,
	output pkg_mpu::t_address_t rd_addr,
	input  pkg_mpu::instr_t     rd_instr,
	output logic                issue_req,
	input  pkg_mpu::issue_no_t  issue_no,
	output logic                run_err,
	output logic                out_valid,
	output pkg_mpu::instr_t     out_instr,
	output pkg_mpu::issue_no_t  out_issue_no,
	output logic                busy
);

	pkg_mpu::disp_state_t state;
	pkg_mpu::t_address_t  addr;
	pkg_mpu::t_length_t   remain;                 // Words still to read
	pkg_mpu::issue_no_t   cur_issue;
	logic                 valid_d;

	assign lookup_req    = run_req & (state == pkg_mpu::IDLE);
	assign lookup_thread = run_thread;
	assign rd_en         = state == pkg_mpu::STREAM;
	assign rd_addr       = addr;
	assign out_instr     = rd_instr;              // Read register feeds output
	assign out_issue_no  = cur_issue;
	assign issue_req     = out_valid & ~valid_d;  // First word of a run
	assign busy          = (state != pkg_mpu::IDLE) | out_valid | commit_full;

	////////////////////////////////////////////////////////////////////////////
	// FSM
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state     <= pkg_mpu::IDLE;
			run_err   <= 1'b0;
			out_valid <= 1'b0;
			valid_d   <= 1'b0;
		end
		else begin
			run_err   <= 1'b0;
			out_valid <= rd_en;                  // Matches read latency
			valid_d   <= out_valid;
			case (state)
				pkg_mpu::IDLE: begin
					if (lookup_req) begin
						state <= pkg_mpu::LOOKUP;
					end
				end
				pkg_mpu::LOOKUP: begin
					if (lookup_info.valid) begin
						state <= pkg_mpu::STREAM;
					end
					else begin
						state   <= pkg_mpu::IDLE;
						run_err <= 1'b1;         // Thread never stored
					end
				end
				pkg_mpu::STREAM: begin
					if (remain == pkg_mpu::t_length_t'(1)) begin
						state <= pkg_mpu::IDLE;
					end
				end
				default: state <= pkg_mpu::IDLE;
			endcase
		end
	end

	// Address and word count of the running thread
	always_ff @(posedge clock) begin
		if (state == pkg_mpu::LOOKUP) begin
			addr      <= lookup_info.base;
			remain    <= lookup_info.length;
			cur_issue <= issue_no;               // Tag held for the whole run
		end
		else if (rd_en) begin
			addr   <= addr + 1'b1;
			remain <= remain - 1'b1;
		end
	end

	// Host waits for busy to fall, which also covers a full commit list
	a_no_run_busy: assert property (
		@(posedge clock) disable iff (!rst_n)
		run_req |-> !busy
	) else $error("run request while busy");

endmodule

// File: verilog/mpu.sv
/*
 * Top level of the thread front end. Host side uses plain strobes,
 * compute-array side gets the tagged instruction stream and commits.
 */

module mpu (
	input  logic               clock,
	input  logic               rst_n,
	input  logic               st_req,
	input  pkg_mpu::st_cmd_t   st_cmd,
	input  logic               st_valid,
	input  pkg_mpu::instr_t    st_instr,
	output logic               st_err,
	input  logic               run_req,
	input  pkg_mpu::id_t       run_thread,
	output logic               run_err,
	output logic               out_valid,
	output pkg_mpu::instr_t    out_instr,
	output pkg_mpu::issue_no_t out_issue_no,
	input  logic               commit_req,
	input  pkg_mpu::issue_no_t commit_no,
	output logic               commit_err,
	output pkg_mpu::mpu_stat_t status
);

	logic                st_grant;
	pkg_mpu::t_length_t  used_size;
	logic                mem_full;
	logic                map_full;
	logic                lookup_req;
	pkg_mpu::id_t        lookup_thread;
	pkg_mpu::lookup_t    lookup_info;
	logic                rd_en;
	pkg_mpu::t_address_t rd_addr;
	pkg_mpu::instr_t     rd_instr;
	logic                issue_req;
	pkg_mpu::issue_no_t  issue_no;
	logic                commit_full;
	logic                busy;

	assign status.mem_full    = mem_full;
	assign status.map_full    = map_full;
	assign status.commit_full = commit_full;
	assign status.busy        = busy;

	thread_mem u_thread_mem (
		.clock(clock), .rst_n(rst_n), .st_grant(st_grant), .st_valid(st_valid),
		.st_instr(st_instr), .used_size(used_size), .rd_en(rd_en),
		.rd_addr(rd_addr), .rd_instr(rd_instr), .mem_full(mem_full)
	);

	map_man u_map_man (
		.clock(clock), .rst_n(rst_n), .st_req(st_req), .st_cmd(st_cmd),
		.used_size(used_size), .st_grant(st_grant), .st_err(st_err),
		.lookup_req(lookup_req), .lookup_thread(lookup_thread),
		.lookup_info(lookup_info), .map_full(map_full)
	);

	dispatch u_dispatch (
		.clock(clock), .rst_n(rst_n), .run_req(run_req), .run_thread(run_thread),
		.commit_full(commit_full), .lookup_req(lookup_req),
		.lookup_thread(lookup_thread), .lookup_info(lookup_info), .rd_en(rd_en),
		.rd_addr(rd_addr), .rd_instr(rd_instr), .issue_req(issue_req),
		.issue_no(issue_no), .run_err(run_err), .out_valid(out_valid),
		.out_instr(out_instr), .out_issue_no(out_issue_no), .busy(busy)
	);

	commit_track u_commit_track (
		.clock(clock), .rst_n(rst_n), .issue_req(issue_req), .issue_no(issue_no),
		.commit_req(commit_req), .commit_no(commit_no), .commit_err(commit_err),
		.commit_full(commit_full)
	);

endmodule

// File: verif/tb_clock.sv
/*
 * Free-running 20 ns clock and a synchronous reset held for
 * 10 rising edges, released 2 ns after an edge.
 */

module tb_clock (
	output logic clock,
	output logic rst_n
);

	timeunit 1ns;
	timeprecision 100ps;

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;          // 20 ns period
	end

	initial begin
		rst_n = 1'b0;
		repeat (10) @(posedge clock);
		#2 rst_n = 1'b1;                     // Same slot as other inputs
	end

endmodule

// File: verif/tb_mpu.sv
/*
 * Table-driven testbench for the thread front end. Inputs change 2 ns
 * after a rising edge, outputs are sampled on the falling edge.
 * Instruction words come from $random with a fixed seed.
 */

module tb_mpu;

	timeunit 1ns;
	timeprecision 100ps;

	typedef enum logic [1:0] {OP_STORE, OP_RUN, OP_COMMIT, OP_WAIT} op_t;

	typedef struct packed {
		op_t                op;
		pkg_mpu::id_t       thread;
		pkg_mpu::t_length_t len;                 // Words, or cycles for a wait
		logic [2:0]         count;               // Times the step is applied
		logic               skip;                // Commit one past the oldest
		logic               exp_flag;            // Error pulse, or full level
	} step_t;

	logic clock;
	logic rst_n;
	logic st_req = 1'b0;
	pkg_mpu::st_cmd_t st_cmd = '0;
	logic st_valid = 1'b0;
	pkg_mpu::instr_t st_instr = '0;
	logic st_err;
	logic run_req = 1'b0;
	pkg_mpu::id_t run_thread = '0;
	logic run_err;
	logic out_valid;
	pkg_mpu::instr_t out_instr;
	pkg_mpu::issue_no_t out_issue_no;
	logic commit_req = 1'b0;
	pkg_mpu::issue_no_t commit_no = '0;
	logic commit_err;
	pkg_mpu::mpu_stat_t status;

	step_t steps [$];
	integer seed = 32'heabe;
	int cycles = 0;
	int limit = 0;

	// Reference model of the map, the store and the outstanding list
	logic [pkg_mpu::NUM_THREADS-1:0] model_valid = '0;
	int model_base [pkg_mpu::NUM_THREADS];
	int model_len [pkg_mpu::NUM_THREADS];
	pkg_mpu::instr_t model_mem [$];          // Append-only, like the store
	pkg_mpu::issue_no_t issued [$];
	pkg_mpu::issue_no_t next_issue = '0;

	tb_clock clock_gen (.clock(clock), .rst_n(rst_n));

	mpu DUT (
		.clock(clock), .rst_n(rst_n), .st_req(st_req), .st_cmd(st_cmd),
		.st_valid(st_valid), .st_instr(st_instr), .st_err(st_err),
		.run_req(run_req), .run_thread(run_thread), .run_err(run_err),
		.out_valid(out_valid), .out_instr(out_instr), .out_issue_no(out_issue_no),
		.commit_req(commit_req), .commit_no(commit_no), .commit_err(commit_err),
		.status(status)
	);

	////////////////////////////////////////////////////////////////////////////
	// Reporting and compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic fail_run(input string why);
		$display("=== FAIL ===");
		$fatal(1, "%s", why);
	endtask

	task automatic check_instr(input string name, input pkg_mpu::instr_t exp,
			input pkg_mpu::instr_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			fail_run("instruction word mismatch");
		end
	endtask

	task automatic check_issue(input string name, input pkg_mpu::issue_no_t exp,
			input pkg_mpu::issue_no_t act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			fail_run("issue number mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (exp !== act) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			fail_run("flag mismatch");
		end
	endtask

	always @(posedge clock) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit) begin
			fail_run($sformatf("run did not finish within %0d cycles", limit));
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Operations
	////////////////////////////////////////////////////////////////////////////

	task automatic past_edge();
		@(posedge clock);
		#2;
	endtask

	task automatic store_thread(input string name, input pkg_mpu::id_t thread,
			input int n, input logic exp_tbl);
		logic exp_err;
		int   k;
		exp_err = model_mem.size() + n > pkg_mpu::SIZE_THREAD_MEM;   // Space rule
		check_flag({name, " model st_err"}, exp_tbl, exp_err);
		past_edge();
		st_req        = 1'b1;
		st_cmd.thread = thread;
		st_cmd.length = pkg_mpu::t_length_t'(n);
		past_edge();
		st_req = 1'b0;
		@(negedge clock);
		check_flag({name, " st_err"}, exp_err, st_err);
		if (!exp_err) begin
			model_valid[thread] = 1'b1;
			model_base[thread]  = model_mem.size();
			model_len[thread]   = n;
			for (k = 0; k < n; k++) begin
				past_edge();
				st_valid = 1'b1;
				st_instr = $random(seed);
				model_mem.push_back(st_instr);
			end
			past_edge();
			st_valid = 1'b0;
		end
		@(negedge clock);
		check_flag({name, " mem_full"}, model_mem.size() == pkg_mpu::SIZE_THREAD_MEM,
			status.mem_full);
		check_flag({name, " map_full"}, &model_valid, status.map_full);
	endtask

	// Cycle t holds run_req; words are due in t+3 to t+2+length
	task automatic start_run(input string name, input pkg_mpu::id_t thread,
			input logic exp_tbl);
		logic               exp_err;
		logic               exp_valid;
		int                 n;
		int                 base;
		int                 i;
		pkg_mpu::issue_no_t tag;
		exp_err = !model_valid[thread];
		n       = exp_err ? 0 : model_len[thread];
		base    = model_base[thread];
		tag     = next_issue;
		check_flag({name, " model run_err"}, exp_tbl, exp_err);
		while (status.busy) begin
			@(negedge clock);
		end
		past_edge();
		run_req    = 1'b1;
		run_thread = thread;
		past_edge();
		run_req = 1'b0;
		for (i = 1; i <= n + 4; i++) begin
			@(negedge clock);
			exp_valid = (i >= 3) && (i <= n + 2);
			check_flag({name, " run_err"}, exp_err && (i == 2), run_err);
			check_flag({name, " out_valid"}, exp_valid, out_valid);
			if (exp_valid) begin
				check_instr({name, " out_instr"}, model_mem[base + i - 3], out_instr);
				check_issue({name, " out_issue_no"}, tag, out_issue_no);
			end
		end
		if (!exp_err) begin
			issued.push_back(tag);
			next_issue = next_issue + pkg_mpu::issue_no_t'(1);   // Wraps at 16
		end
	endtask

	task automatic commit_number(input string name, input logic skip, input logic exp_tbl);
		pkg_mpu::issue_no_t no;
		logic               exp_err;
		no      = (issued.size() > 0) ? issued[0] : next_issue;
		no      = skip ? no + pkg_mpu::issue_no_t'(1) : no;
		exp_err = (issued.size() == 0) ? 1'b1 : (no != issued[0]);   // Oldest only
		check_flag({name, " model commit_err"}, exp_tbl, exp_err);
		past_edge();
		commit_req = 1'b1;
		commit_no  = no;
		past_edge();
		commit_req = 1'b0;
		@(negedge clock);
		check_flag({name, " commit_err"}, exp_err, commit_err);
		if (!exp_err) begin
			void'(issued.pop_front());
		end
		check_flag({name, " commit_full"}, issued.size() == pkg_mpu::NUM_ISSUE,
			status.commit_full);
	endtask

	task automatic hold_idle(input string name, input int n, input logic level);
		int c;
		check_flag({name, " model full"}, level, issued.size() == pkg_mpu::NUM_ISSUE);
		for (c = 0; c < n; c++) begin
			@(negedge clock);
			check_flag({name, " commit_full"}, level, status.commit_full);
			check_flag({name, " busy"}, level, status.busy);
		end
	endtask

	function automatic void add_step(input op_t op, input int thread, input int len,
			input int count, input int skip, input int exp_flag);
		step_t s;
		s.op       = op;
		s.thread   = pkg_mpu::id_t'(thread);
		s.len      = pkg_mpu::t_length_t'(len);
		s.count    = 3'(count);
		s.skip     = skip != 0;
		s.exp_flag = exp_flag != 0;
		steps.push_back(s);
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// Stimulus table and main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int    idx;
		int    rep;
		string name;
		add_step(OP_STORE,  0,  5, 1, 0, 0);
		add_step(OP_STORE,  1, 12, 1, 0, 0);
		add_step(OP_STORE,  2,  1, 1, 0, 0);
		add_step(OP_RUN,    0,  5, 1, 0, 0);    // Issue 0
		add_step(OP_RUN,    1, 12, 1, 0, 0);
		add_step(OP_RUN,    2,  1, 1, 0, 0);
		add_step(OP_COMMIT, 0,  0, 3, 0, 0);
		add_step(OP_RUN,    5,  0, 1, 0, 1);    // Never stored
		add_step(OP_RUN,    2,  1, 4, 0, 0);    // Issues 3 to 6 fill the list
		add_step(OP_WAIT,   0, 10, 1, 0, 1);
		add_step(OP_COMMIT, 0,  0, 1, 1, 1);    // Out of order
		add_step(OP_COMMIT, 0,  0, 1, 0, 0);
		add_step(OP_WAIT,   0,  3, 1, 0, 0);
		add_step(OP_RUN,    0,  5, 1, 0, 0);    // Issue 7
		add_step(OP_COMMIT, 0,  0, 4, 0, 0);
		add_step(OP_RUN,    2,  1, 4, 0, 0);
		add_step(OP_COMMIT, 0,  0, 4, 0, 0);
		add_step(OP_RUN,    2,  1, 4, 0, 0);    // Up to issue 15
		add_step(OP_COMMIT, 0,  0, 4, 0, 0);
		add_step(OP_RUN,    1, 12, 1, 0, 0);    // Tag wraps to 0
		add_step(OP_COMMIT, 0,  0, 1, 0, 0);
		add_step(OP_STORE,  0,  6, 1, 0, 0);    // Replaces thread 0
		add_step(OP_RUN,    0,  6, 1, 0, 0);
		add_step(OP_COMMIT, 0,  0, 1, 0, 0);
		add_step(OP_STORE,  4,  1, 1, 0, 0);    // Threads 4 to 7 take one word each
		add_step(OP_STORE,  5,  1, 1, 0, 0);
		add_step(OP_STORE,  6,  1, 1, 0, 0);
		add_step(OP_STORE,  7,  1, 1, 0, 0);
		add_step(OP_STORE,  3, 37, 1, 0, 1);    // One word too many
		add_step(OP_STORE,  3, 36, 1, 0, 0);    // Fills the store and the map
		add_step(OP_STORE,  4,  1, 1, 0, 1);
		add_step(OP_RUN,    3, 36, 1, 0, 0);
		add_step(OP_COMMIT, 0,  0, 1, 0, 0);
		add_step(OP_WAIT,   0,  2, 1, 0, 0);

		for (idx = 0; idx < steps.size(); idx++) begin
			limit = limit + 2 * int'(steps[idx].count) * int'(steps[idx].len);
		end
		limit = limit + 200;

		wait (rst_n === 1'b1);
		@(negedge clock);
		check_flag("reset outputs", 1'b0,
			|{out_valid, st_err, run_err, commit_err, status});

		for (idx = 0; idx < steps.size(); idx++) begin
			name = $sformatf("step %0d", idx);
			for (rep = 0; rep < int'(steps[idx].count); rep++) begin
				case (steps[idx].op)
					OP_STORE:  store_thread(name, steps[idx].thread, int'(steps[idx].len),
						steps[idx].exp_flag);
					OP_RUN:    start_run(name, steps[idx].thread, steps[idx].exp_flag);
					OP_COMMIT: commit_number(name, steps[idx].skip, steps[idx].exp_flag);
					default:   hold_idle(name, int'(steps[idx].len), steps[idx].exp_flag);
				endcase
			end
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule

// File: verilog.f
verilog/pkg_mpu.sv
verilog/thread_mem.sv
verilog/map_man.sv
verilog/commit_track.sv
verilog/dispatch.sv
verilog/mpu.sv
verif/tb_clock.sv
verif/tb_mpu.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the mpu testbench with Verilator and runs it.
# Exit status is non-zero when the build or the simulation fails.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	-f verilog.f --top-module tb_mpu -o sim_mpu
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/sim_mpu
status=$?
if [ $status -ne 0 ]; then
	echo "Simulation ended with status $status"
	exit $status
fi

exit 0
